// File: dv/camera_stream_testdata.txt
# columns: vsync href data key expected, data is a hex byte
# expected is the 24-bit {r,g,b} word in hex, or - when no pixel is due
0 1 f8 0 -
0 1 00 0 0000f8
0 1 12 0 -
0 1 34 0 a04410
0 1 55 0 -
0 0 00 0 -
0 1 00 0 -
0 1 1f 0 f80000
0 1 66 0 -
1 1 77 0 -
1 0 00 0 -
0 0 00 0 -
0 1 ab 0 -
0 1 cd 0 6878a8
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 1 f8 1 -
0 1 00 1 f8fc00
0 1 12 1 -
0 1 34 1 58b8e8
0 1 00 1 -
0 1 00 1 f8fcf8
0 0 00 0 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 0 00 1 -
0 1 ab 1 -
0 1 cd 1 6878a8
0 1 07 1 -
0 1 e0 1 00fc00
1 0 00 1 -
1 0 00 1 -
1 0 00 1 -
0 0 00 1 -

// File: sim.f
hw/cam_pkg.sv
hw/byte_pair_packer.sv
hw/pixel_formatter.sv
hw/key_toggle.sv
hw/heartbeat_blink.sv
hw/camera_stream_top.sv
dv/camera_stream_sva.sv
dv/tb_camera_stream.sv

// File: run_sim.sh
#!/bin/sh
# build and run the camera stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timing --top-module tb_camera_stream \
    -f sim.f -o tb_camera_stream
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_camera_stream > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
    exit 1
fi
if ! grep -q "=== PASS ===" "$log"; then
    echo "no pass line found in $log"
    exit 1
fi
exit 0

// File: dv/tb_camera_stream.sv
module tb_camera_stream
    import cam_pkg::*;
();

    logic      core_clk;
    logic      rst_n_i;
    cam_byte_t cam_data_i;
    logic      cam_href_i;
    logic      cam_vsync_i;
    logic      key_reverse_i;
    logic      vs_o;
    logic      de_o;
    chan8_t    r_o;
    chan8_t    g_o;
    chan8_t    b_o;
    logic      heartbeat_led_o;

    logic [35:0] step_q[$];                         // {has_pixel, rgb, vsync, href, data, key}
    logic [23:0] want_q[$];                         // expected pixels in arrival order
    int          pix_idx      = 0;                  // next expected pixel
    int          errors       = 0;
    int          checks       = 0;
    int          cycle_cnt    = 0;
    int          cycle_limit  = 0;                  // zero until testdata is read
    int          toggles      = 0;                  // heartbeat toggles seen
    int          since_toggle = 0;                  // cycles since last toggle
    logic        led_last     = 1'b1;
    logic [1:0]  vs_hist      = 2'b00;              // vsync taken at the last two edges

    camera_stream_top dut0
    (
        .core_clk        (core_clk),
        .rst_n_i         (rst_n_i),
        .cam_data_i      (cam_data_i),
        .cam_href_i      (cam_href_i),
        .cam_vsync_i     (cam_vsync_i),
        .key_reverse_i   (key_reverse_i),
        .vs_o            (vs_o),
        .de_o            (de_o),
        .r_o             (r_o),
        .g_o             (g_o),
        .b_o             (b_o),
        .heartbeat_led_o (heartbeat_led_o)
    );

    always #20 core_clk = ~core_clk;               // 40 unit period

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // one camera bus step launched on the falling edge
    task automatic apply_step(input logic vs, input logic hr, input cam_byte_t data,
                              input logic key);
        @(negedge core_clk);
        cam_vsync_i   <= vs;
        cam_href_i    <= hr;
        cam_data_i    <= data;
        key_reverse_i <= key;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // vsync history and timeout

    always @(posedge core_clk)
    begin
        vs_hist   <= {vs_hist[0], cam_vsync_i};
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout after %0d cycles, the run never reached its end", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor sampled mid cycle

    always @(negedge core_clk)
    begin
        if (!rst_n_i)
            check_value(32'(heartbeat_led_o), 32'd1, "heartbeat_led_o in reset");
        else
        begin
            check_value(32'(vs_o), 32'(vs_hist[1]), "vs_o vs cam_vsync_i two cycles back");
            if (de_o && pix_idx >= want_q.size())
            begin
                errors++;
                $display("de_o high at time %0t with no expected pixel left", $time);
            end
            else if (de_o)
            begin
                check_value(32'({r_o, g_o, b_o}), 32'(want_q[pix_idx]), "pixel {r,g,b}");
                pix_idx++;
            end
            since_toggle++;
            if (heartbeat_led_o !== led_last)
            begin
                check_value(since_toggle, 32'd64, "cycles between heartbeat toggles");
                toggles++;
                since_toggle = 0;
            end
            led_last = heartbeat_led_o;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial
    begin
        int          fd;
        int          n;
        int          gap;
        int          missing;
        string       line;
        logic        vs;
        logic        hr;
        logic        key;
        logic        last_key;
        cam_byte_t   data;
        logic [23:0] rgb;

        core_clk      = 1'b0;
        rst_n_i       = 1'b1;
        cam_data_i    = '0;
        cam_href_i    = 1'b0;
        cam_vsync_i   = 1'b0;
        key_reverse_i = 1'b0;
        last_key      = 1'b0;
        void'($urandom(32'hc55d_f4cf));            // single seed for all gaps

        fd = $fopen("dv/camera_stream_testdata.txt", "r");
        if (fd == 0)
            $display("cannot open dv/camera_stream_testdata.txt, no stimulus applied");
        while (fd != 0 && !$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#")
                continue;                           // blank or column note
            n = $sscanf(line, "%h %h %h %h %h", vs, hr, data, key, rgb);
            if (n < 4)
                continue;
            if (n == 5)
                want_q.push_back(rgb);              // a dash leaves n at 4
            step_q.push_back({n == 5, rgb, vs, hr, data, key});
        end
        if (fd != 0)
            $fclose(fd);
        cycle_limit = step_q.size() + 3 * want_q.size() + 200;

        #1 rst_n_i = 1'b0;                         // falling edge fires the async reset
        repeat (8) @(negedge core_clk);
        rst_n_i <= 1'b1;

        foreach (step_q[i])
        begin
            last_key = step_q[i][0];
            apply_step(step_q[i][10], step_q[i][9], step_q[i][8:1], last_key);
            if (step_q[i][35])
            begin
                gap = int'($urandom % 4);           // 0..3 idle cycles after a pair
                repeat (gap)
                    apply_step(1'b0, 1'b0, 8'h00, last_key);
            end
        end

        // idle until the heartbeat has shown three toggles
        while (toggles < 3)
            @(posedge core_clk);

        missing = want_q.size() - pix_idx;
        if (missing > 0)
            $display("%0d expected pixels never appeared on de_o", missing);
        if (want_q.size() == 0)
        begin
            $display("testdata held no expected pixels");
            missing++;
        end
        $display("checks %0d, errors %0d, missing pixels %0d", checks, errors, missing);
        if (errors == 0 && missing == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: dv/camera_stream_sva.sv
module camera_stream_sva
    import cam_pkg::*;
(
    input logic   core_clk,
    input logic   rst_n_i,
    input logic   de_i,                             // top de_o
    input logic   vs_i,                             // top vs_o
    input chan8_t r_i,
    input chan8_t g_i,
    input chan8_t b_i,
    input logic   heartbeat_led_i
);

    // one packer strobe per pair, so enables never touch
    de_gap_a: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        de_i |=> !de_i)
        else $error("de_o high on two consecutive cycles");

    led_reset_a: assert property (@(posedge core_clk)
        !rst_n_i |-> heartbeat_led_i)
        else $error("heartbeat_led_o low during reset");

    idle_reset_a: assert property (@(posedge core_clk)
        !rst_n_i |-> (!de_i && !vs_i))
        else $error("de_o or vs_o high during reset");

    // channels only carry data behind de
    rgb_known_a: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        de_i |-> !$isunknown({r_i, g_i, b_i}))
        else $error("r/g/b unknown while de_o is high");

endmodule

bind camera_stream_top camera_stream_sva u_sva
(
    .core_clk        (core_clk),
    .rst_n_i         (rst_n_i),
    .de_i            (de_o),
    .vs_i            (vs_o),
    .r_i             (r_o),
    .g_i             (g_o),
    .b_i             (b_o),
    .heartbeat_led_i (heartbeat_led_o)
);

// File: hw/camera_stream_top.sv
module camera_stream_top
    import cam_pkg::*;
(
    input  logic      core_clk,
    input  logic      rst_n_i,
    input  cam_byte_t cam_data_i,                   // camera byte bus
    input  logic      cam_href_i,                   // line valid
    input  logic      cam_vsync_i,                  // frame sync
    input  logic      key_reverse_i,                // colour-reverse button
    output logic      vs_o,                         // vsync delayed 2 cycles
    output logic      de_o,                         // pixel enable
    output chan8_t    r_o,
    output chan8_t    g_o,
    output chan8_t    b_o,
    output logic      heartbeat_led_o
);

    logic    pix_valid;                             // packer pixel strobe
    rgb565_t pix_data;                              // packed pixel
    logic    pix_vsync;                             // packer vsync
    logic    reverse_en;                            // colour inversion mode

    ////////////////////////////////////////////////////////////////////////////
    // capture path

    byte_pair_packer u_packer
    (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .cam_data_i  (cam_data_i),
        .cam_href_i  (cam_href_i),
        .cam_vsync_i (cam_vsync_i),
        .pix_valid_o (pix_valid),
        .pix_data_o  (pix_data),
        .pix_vsync_o (pix_vsync)
    );

    pixel_formatter u_formatter
    (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .pix_valid_i  (pix_valid),
        .pix_data_i   (pix_data),
        .pix_vsync_i  (pix_vsync),
        .reverse_en_i (reverse_en),
        .de_o         (de_o),
        .vs_o         (vs_o),
        .r_o          (r_o),
        .g_o          (g_o),
        .b_o          (b_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // key and status

    key_toggle u_key_reverse
    (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .key_i        (key_reverse_i),
        .reverse_en_o (reverse_en)
    );

    heartbeat_blink u_heartbeat
    (
        .core_clk        (core_clk),
        .rst_n_i         (rst_n_i),
        .heartbeat_led_o (heartbeat_led_o)
    );

endmodule

// File: hw/heartbeat_blink.sv
module heartbeat_blink
    import cam_pkg::*;
(
    input  logic core_clk,
    input  logic rst_n_i,
    output logic heartbeat_led_o                    // blinking alive indicator
);

    heart_cnt_t cnt_q;                              // cycle counter
    logic       wrap;                               // counter at its top

    assign wrap = (cnt_q == HEARTBEAT_TICKS);

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            cnt_q <= '0;
        else if (wrap)
            cnt_q <= '0;                            // restart period
        else
            cnt_q <= cnt_q + 1'b1;
    end

    // led lit while in reset, then toggles once per period
    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            heartbeat_led_o <= 1'b1;
        else if (wrap)
            heartbeat_led_o <= ~heartbeat_led_o;
    end

endmodule

// File: hw/key_toggle.sv
module key_toggle
(
    input  logic core_clk,
    input  logic rst_n_i,
    input  logic key_i,                             // raw asynchronous push-button
    output logic reverse_en_o                       // colour-reverse mode
);

    logic key_meta_q;                               // first sync flop
    logic key_sync_q;                               // second sync flop
    logic key_last_q;                               // previous synced level
    logic press_q;                                  // registered rising edge
    logic step_q;                                   // one-bit step counter

    ////////////////////////////////////////////////////////////////////////////
    // synchroniser and edge detect

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            key_meta_q <= 1'b0;
            key_sync_q <= 1'b0;
            key_last_q <= 1'b0;
            press_q    <= 1'b0;
        end
        else
        begin
            key_meta_q <= key_i;
            key_sync_q <= key_meta_q;
            key_last_q <= key_sync_q;
            press_q    <= key_sync_q & ~key_last_q; // low-to-high only
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // step counter wrapping after its max of 1

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            step_q <= 1'b0;
        else if (press_q)
            step_q <= step_q + 1'b1;                // each press flips the mode
    end

    assign reverse_en_o = step_q;

endmodule

// File: hw/pixel_formatter.sv
module pixel_formatter
    import cam_pkg::*;
(
    input  logic    core_clk,
    input  logic    rst_n_i,
    input  logic    pix_valid_i,                    // pixel strobe from packer
    input  rgb565_t pix_data_i,                     // packed pixel
    input  logic    pix_vsync_i,                    // delayed vsync
    input  logic    reverse_en_i,                   // colour inversion on
    output logic    de_o,                           // output data enable
    output logic    vs_o,                           // output vsync
    output chan8_t  r_o,
    output chan8_t  g_o,
    output chan8_t  b_o
);

    rgb565_t swapped;                               // red and blue exchanged
    rgb565_t shaded;                                // after optional inversion

    // camera sends blue in the top field, display wants red there
    assign swapped = {pix_data_i[4:0], pix_data_i[10:5], pix_data_i[15:11]};
    assign shaded  = reverse_en_i ? ~swapped : swapped;

    ////////////////////////////////////////////////////////////////////////////
    // output register stage

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            de_o <= 1'b0;
            vs_o <= 1'b0;
        end
        else
        begin
            de_o <= pix_valid_i;                    // one cycle behind the packer
            vs_o <= pix_vsync_i;
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (pix_valid_i)
        begin
            r_o <= {shaded[15:11], 3'b000};         // zero filled from 5 to 8 bits
            g_o <= {shaded[10:5], 2'b00};           // 6 -> 8 bits
            b_o <= {shaded[4:0], 3'b000};
        end
    end

endmodule

// File: hw/byte_pair_packer.sv
module byte_pair_packer
    import cam_pkg::*;
(
    input  logic      core_clk,
    input  logic      rst_n_i,
    input  cam_byte_t cam_data_i,                   // camera byte
    input  logic      cam_href_i,                   // byte qualifier
    input  logic      cam_vsync_i,                  // frame sync
    output logic      pix_valid_o,                  // one-cycle strobe per pixel
    output rgb565_t   pix_data_o,                   // joined pixel
    output logic      pix_vsync_o                   // vsync one cycle late
);

    pack_phase_e phase_q;                           // packer FSM
    cam_byte_t   hi_byte_q;                         // first byte of the pair

    logic take_byte;                                // byte accepted this edge

    assign take_byte = cam_href_i & ~cam_vsync_i;

    ////////////////////////////////////////////////////////////////////////////
    // phase and valid strobe

    always_ff @(posedge core_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            phase_q     <= PHASE_HIGH;
            pix_valid_o <= 1'b0;
            pix_vsync_o <= 1'b0;
        end
        else
        begin
            pix_valid_o <= 1'b0;                    // strobe by default low
            pix_vsync_o <= cam_vsync_i;             // keeps framing aligned with pixels
            if (!take_byte)
                phase_q <= PHASE_HIGH;              // drop any half pair
            else if (phase_q == PHASE_HIGH)
                phase_q <= PHASE_LOW;
            else
            begin
                phase_q     <= PHASE_HIGH;
                pix_valid_o <= 1'b1;                // pair complete
            end
        end
    end

    // payload qualified by phase and pix_valid_o
    always_ff @(posedge core_clk)
    begin
        if (take_byte && phase_q == PHASE_HIGH)
            hi_byte_q <= cam_data_i;                // upper half
        if (take_byte && phase_q == PHASE_LOW)
            pix_data_o <= {hi_byte_q, cam_data_i};  // first byte on top
    end

endmodule

// File: hw/cam_pkg.sv
package cam_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // pixel path types

    typedef logic [7:0]  cam_byte_t;                // one byte off the camera bus
    typedef logic [15:0] rgb565_t;                  // [15:11] first field, [10:5] green, [4:0] last
    typedef logic [7:0]  chan8_t;                   // widened output channel

    // which half of the rgb565 word the next byte fills
    typedef enum logic
    {
        PHASE_HIGH,                                 // waiting for upper byte
        PHASE_LOW                                   // upper byte held, waiting for lower
    } pack_phase_e;

    ////////////////////////////////////////////////////////////////////////////
    // heartbeat

    typedef logic [5:0] heart_cnt_t;                // wide enough for the wrap count

    // toggle period is HEARTBEAT_TICKS+1 cycles
    localparam heart_cnt_t HEARTBEAT_TICKS = 6'd63;

endpackage
